// File: runSim.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
verilator --binary --timing --assert -Wno-fatal -f rv32Core.f \
    --top-module rv32CoreTb -o rv32CoreSim \
    && out=$(./obj_dir/rv32CoreSim) \
    && echo "$out" \
    && echo "$out" | grep -q "^Test OK$" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: rv32Core.f
+incdir+include
src/rv32Pkg.sv
src/alu.sv
src/immGen.sv
src/regFile.sv
src/instrDecoder.sv
src/executeStage.sv
src/fetchUnit.sv
src/rv32Core.sv
sim/rv32CoreTb.sv

// File: include/tbProgram.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

function automatic wordT encR(input logic [6:0] f7, input logic [2:0] f3,
                              input int rd, input int rs1, input int rs2);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], opReg};
endfunction

function automatic wordT encI(input opcodeE op, input logic [2:0] f3,
                              input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
endfunction

function automatic wordT encS(input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3Word, imm[4:0], opStore};
endfunction

function automatic wordT encB(input logic [2:0] f3, input int rs1, input int rs2, input int imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], opBranch};
endfunction

function automatic wordT encU(input opcodeE op, input int rd, input int imm);
    return {imm[19:0], rd[4:0], op};
endfunction

function automatic wordT encJ(input int rd, input int imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], opJal};
endfunction

// Program words plus the pc expected after each of them
task automatic loadProgram();
    for (int i = 0; i < 128; i++)
    begin
        rom[i[6:0]]     = {i[24:0], 7'h7f};     // Undefined opcode outside the program
        expNext[i[6:0]] = wordT'(i * 4 + 4);
    end
    rom[0]  = encU(opLui, 1, 32'h12345);
    rom[1]  = encI(opImm, f3AddSub, 1, 1, 32'h678);
    rom[2]  = encI(opImm, f3AddSub, 2, 0, -5);
    rom[3]  = encI(opImm, f3AddSub, 3, 0, 7);
    rom[4]  = encR(f7Base, f3AddSub, 4, 1, 2);
    rom[5]  = encS(4, 0, 32'h100);
    rom[6]  = encR(f7Alt, f3AddSub, 4, 1, 3);
    rom[7]  = encS(4, 0, 32'h104);
    rom[8]  = encR(f7Base, f3And, 4, 1, 2);
    rom[9]  = encS(4, 0, 32'h108);
    rom[10] = encR(f7Base, f3Slt, 4, 2, 3);     // -5 < 7
    rom[11] = encS(4, 0, 32'h10c);
    rom[12] = encR(f7Base, f3Slt, 4, 3, 2);
    rom[13] = encS(4, 0, 32'h110);
    rom[14] = encR(f7Base, f3Sll, 4, 1, 3);
    rom[15] = encS(4, 0, 32'h114);
    rom[16] = encR(f7Base, f3Shr, 4, 2, 3);
    rom[17] = encS(4, 0, 32'h118);
    rom[18] = encR(f7Alt, f3Shr, 4, 2, 3);
    rom[19] = encS(4, 0, 32'h11c);
    rom[20] = encI(opLoad, f3Word, 5, 0, 32'h20);
    rom[21] = encI(opImm, f3AddSub, 5, 5, 1);
    rom[22] = encS(5, 0, 32'h120);
    rom[23] = encB(f3Beq, 3, 3, 8);             // Taken
    rom[24] = encS(3, 0, 32'h1fc);              // Skipped stores all hit 0x1fc
    rom[25] = encB(f3Beq, 3, 2, 8);             // Not taken
    rom[26] = encI(opImm, f3AddSub, 6, 0, 1);
    rom[27] = encB(f3Blt, 2, 3, 8);             // Signed taken, unsigned would not be
    rom[28] = encS(3, 0, 32'h1fc);
    rom[29] = encB(f3Blt, 3, 2, 8);
    rom[30] = encS(6, 0, 32'h124);
    rom[31] = encJ(7, 8);
    rom[32] = encS(3, 0, 32'h1fc);
    rom[33] = encS(7, 0, 32'h128);
    rom[34] = encI(opImm, f3AddSub, 9, 0, 37 * 4 + 1);  // Odd jalr target
    rom[35] = encI(opJalr, f3Jalr, 8, 9, 0);
    rom[36] = encS(3, 0, 32'h1fc);
    rom[37] = encS(8, 0, 32'h12c);
    rom[38] = encU(opAuipc, 10, 1);
    rom[39] = encS(10, 0, 32'h130);
    rom[40] = encI(opImm, f3AddSub, 0, 0, 5);
    rom[41] = encS(0, 0, 32'h134);
    rom[42] = 32'hffffffff;
    rom[43] = encJ(0, 0);                       // End loop
    expNext[23] = 23 * 4 + 8;
    expNext[27] = 27 * 4 + 8;
    expNext[31] = 31 * 4 + 8;
    expNext[35] = 37 * 4;
    expNext[43] = 43 * 4;
endtask

`endif

// File: sim/rv32CoreTb.sv
`timescale 1ns/10ps

module rv32CoreTb import rv32Pkg::*; ();

    localparam int progLen       = 44;
    localparam int nStores       = 14;
    localparam int timeoutCycles = 4 * progLen + 24;   // Generous margin over one pass

    logic   clk = 1'b0;
    logic   reset;
    wordT   pc;
    wordT   instruction;
    logic   we;
    wordT   addressToMem;
    wordT   dataToMem;
    wordT   dataFromMem;

    wordT   rom [128];
    wordT   expNext [128];
    wordT   ram [128];
    wordT   expAddr [16];
    wordT   expData [16];
    string  testName [16];
    wordT   resetInstr;           // Store word offered while reset is held

    integer seed;
    int     storeIdx = 0;
    int     cycles = 0;
    int     sameCount = 0;
    int     passCount = 0;
    int     failCount = 0;
    logic   done = 1'b0;
    logic   rstQ = 1'b0;          // Reset as seen at the last rising edge
    logic   prevValid = 1'b0;
    wordT   prevPc = '0;
    logic   storeBad = 1'b0;
    logic   pcBad = 1'b0;
    logic   resetBad = 1'b0;
    logic   unknownBad = 1'b0;

    `include "tbProgram.svh"

    rv32Core #(.resetVector(32'h0)) dut0 (
        .clk          (clk),
        .reset        (reset),
        .pc           (pc),
        .instruction  (instruction),
        .we           (we),
        .addressToMem (addressToMem),
        .dataToMem    (dataToMem),
        .dataFromMem  (dataFromMem)
    );

    always #4 clk = ~clk;

    // During reset the core sees a store, which the decoder must suppress
    assign instruction = reset ? resetInstr : rom[pc[8:2]];
    assign dataFromMem = ram[addressToMem[8:2]];

    task automatic valueError(input string name, input wordT expVal, input wordT actVal);
        $display("[ERROR] %s expected %h actual %h", name, expVal, actVal);
    endtask

    task automatic setStore(input int k, input string name, input wordT data);
        testName[k] = name;
        expAddr[k]  = wordT'(32'h100 + 4 * k);
        expData[k]  = data;
    endtask

    // Expected store values worked out from the operands in the program
    task automatic buildExpected();
        wordT opA;
        wordT opB;
        wordT opC;
        opA = 32'h12345678;
        opB = wordT'(-5);
        opC = 32'd7;
        setStore(0, "add", opA + opB);
        setStore(1, "sub", opA - opC);
        setStore(2, "and", opA & opB);
        setStore(3, "sltNeg", ($signed(opB) < $signed(opC)) ? 32'd1 : 32'd0);
        setStore(4, "sltPos", ($signed(opC) < $signed(opB)) ? 32'd1 : 32'd0);
        setStore(5, "sll", opA << opC[4:0]);
        setStore(6, "srl", opB >> opC[4:0]);
        setStore(7, "sra", wordT'($signed(opB) >>> opC[4:0]));
        setStore(8, "loadAdd", ram[8] + 32'd1);
        setStore(9, "branches", 32'd1);
        setStore(10, "jalLink", 31 * 4 + 4);
        setStore(11, "jalrLink", 35 * 4 + 4);
        setStore(12, "auipc", 38 * 4 + 32'h1000);
        setStore(13, "zeroReg", 32'd0);
    endtask

    task automatic finishStore();
        if (storeIdx < nStores)
        begin
            if (storeBad)
                failCount++;
            else
                passCount++;
            $display("%-10s %s", testName[storeIdx], storeBad ? "fail" : "pass");
        end
        else
        begin
            failCount++;
        end
        storeIdx++;
        storeBad = 1'b0;
    endtask

    task automatic reportTest(input string name, input logic bad);
        if (bad)
            failCount++;
        else
            passCount++;
        $display("%-10s %s", name, bad ? "fail" : "pass");
    endtask

    always @(posedge clk)
    begin
        rstQ      <= reset;
        prevValid <= !reset;
        prevPc    <= pc;
        if (we)
        begin
            ram[addressToMem[8:2]] <= dataToMem;
            finishStore();
        end
        if (!reset)
        begin
            cycles++;
            if (prevValid && pc == prevPc)   // jal-to-self reached
                sameCount++;
            else
                sameCount = 0;
            done = (sameCount >= 2);
        end
    end

    // Checks sample on the falling edge, half a cycle after everything settled
    resetPc: assert property (@(negedge clk) rstQ |-> pc == '0)
    else
    begin
        resetBad = 1'b1;
        valueError("resetState", '0, pc);
    end

    resetWe: assert property (@(negedge clk) rstQ |-> !we)
    else
    begin
        resetBad = 1'b1;
        $display("we went high while reset was active");
    end

    pcNext: assert property (@(negedge clk) disable iff (rstQ)
            prevValid |-> pc == expNext[prevPc[8:2]])
    else
    begin
        pcBad = 1'b1;
        valueError("pcSequence", expNext[prevPc[8:2]], pc);
    end

    storeAddr: assert property (@(negedge clk) disable iff (rstQ)
            (we && storeIdx < nStores) |-> addressToMem == expAddr[storeIdx])
    else
    begin
        storeBad = 1'b1;
        valueError(testName[storeIdx], expAddr[storeIdx], addressToMem);
    end

    storeData: assert property (@(negedge clk) disable iff (rstQ)
            (we && storeIdx < nStores) |-> dataToMem == expData[storeIdx])
    else
    begin
        storeBad = 1'b1;
        valueError(testName[storeIdx], expData[storeIdx], dataToMem);
    end

    extraStore: assert property (@(negedge clk) disable iff (rstQ) we |-> storeIdx < nStores)
        else $display("unexpected store to %h after all expected stores", addressToMem);

    unknownOp: assert property (@(negedge clk) disable iff (rstQ)
            (instruction[6:0] == 7'h7f) |-> !we)
    else
    begin
        unknownBad = 1'b1;
        $display("undefined opcode wrote to memory");
    end

    initial
    begin
        reset      = 1'b1;
        resetInstr = encS(0, 0, 32'h1fc);
        seed       = 85;
        for (int i = 0; i < 128; i++)
        begin
            ram[i[6:0]] = $random(seed);
        end
        loadProgram();
        buildExpected();

        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        while (!done && cycles < timeoutCycles)
        begin
            @(negedge clk);
        end

        if (!done)
        begin
            $display("program never reached its end loop within %0d cycles", timeoutCycles);
            $display("Test FAILED");
        end
        else
        begin
            reportTest("pcSequence", pcBad);
            reportTest("resetState", resetBad);
            reportTest("unknownOp", unknownBad);
            if (storeIdx < nStores)
            begin
                $display("only %0d of %0d expected stores were seen", storeIdx, nStores);
                failCount++;
            end
            $display("tests passed %0d, failed %0d", passCount, failCount);
            if (failCount == 0)
                $display("Test OK");
            else
                $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: src/alu.sv
`timescale 1ns/10ps

module alu import rv32Pkg::*; (
    input  wordT  srcA,
    input  wordT  srcB,
    input  aluOpE aluOp,
    output wordT  result,
    output logic  zero
);

    logic [4:0] shamt;

    assign shamt = srcB[4:0];   // RV32 shifts use 5 bits

    always_comb
    begin
        case (aluOp)
            aluAdd:
                result = srcA + srcB;
            aluAnd:
                result = srcA & srcB;
            aluSub:
                result = srcA - srcB;
            aluSlt:
                result = {31'b0, $signed(srcA) < $signed(srcB)};
            aluSll:
                result = srcA << shamt;
            aluSrl:
                result = srcA >> shamt;
            aluSra:
                result = wordT'($signed(srcA) >>> shamt);
            default:
                result = '0;            // aluZero
        endcase
    end

    assign zero = (result == '0);

endmodule

// File: src/executeStage.sv
`timescale 1ns/10ps

module executeStage import rv32Pkg::*; (
    input  wordT   pc,
    input  wordT   pcPlus4,
    input  wordT   rs1Data,
    input  wordT   rs2Data,
    input  wordT   imm,
    input  logic   aluSrcImm,
    input  aluOpE  aluOp,
    input  wbSelE  wbSel,
    input  branchE branchKind,
    input  wordT   dataFromMem,
    output logic   takeBranch,
    output wordT   branchTarget,
    output wordT   addressToMem,
    output wordT   dataToMem,
    output wordT   writeData
);

    wordT srcB;
    wordT aluResult;
    logic aluZeroFlag;
    wordT pcImm;

    assign srcB = aluSrcImm ? imm : rs2Data;

    alu alu0 (
        .srcA   (rs1Data),
        .srcB   (srcB),
        .aluOp  (aluOp),
        .result (aluResult),
        .zero   (aluZeroFlag)
    );

    assign pcImm = pc + imm;    // Branch, jal and auipc share this adder

    always_comb
    begin
        case (branchKind)
            brBeq:   takeBranch = aluZeroFlag;
            brBlt:   takeBranch = aluResult[0];     // slt result
            brJal,
            brJalr:  takeBranch = 1'b1;
            default: takeBranch = 1'b0;
        endcase
    end

    assign branchTarget = (branchKind == brJalr) ? {aluResult[31:1], 1'b0} : pcImm;

    assign addressToMem = aluResult;
    assign dataToMem    = rs2Data;

    always_comb
    begin
        case (wbSel)
            wbMem:     writeData = dataFromMem;
            wbPcPlus4: writeData = pcPlus4;         // Link for jal and jalr
            wbImm:     writeData = imm;             // lui
            wbPcImm:   writeData = pcImm;           // auipc
            default:   writeData = aluResult;
        endcase
    end

endmodule

// File: src/fetchUnit.sv
`timescale 1ns/10ps

module fetchUnit import rv32Pkg::*; #(
    parameter wordT resetVector = '0
) (
    input  logic clk,
    input  logic reset,
    input  logic takeBranch,
    input  wordT branchTarget,
    output wordT pc,
    output wordT pcPlus4
);

    wordT nextPc;

    assign pcPlus4 = pc + 32'd4;
    assign nextPc  = takeBranch ? branchTarget : pcPlus4;   // Taken branch or jump wins

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pc <= resetVector;
        end
        else
        begin
            pc <= nextPc;
        end
    end

    // Targets come from the execute stage, so a bad immediate or jalr sum shows up here
    pcAligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else $error("pc not word-aligned: %h", pc);

endmodule

// File: src/immGen.sv
`timescale 1ns/10ps

module immGen import rv32Pkg::*; (
    input  wordT    instruction,
    input  immTypeE immType,
    output wordT    imm
);

    logic sign;

    assign sign = instruction[31];

    always_comb
    begin
        case (immType)
            immI:
                imm = {{20{sign}}, instruction[31:20]};
            immS:
                imm = {{20{sign}}, instruction[31:25], instruction[11:7]};
            immB:   // Offset in halfwords, bit 0 always zero
                imm = {{19{sign}}, sign, instruction[7], instruction[30:25],
                       instruction[11:8], 1'b0};
            immU:
                imm = {instruction[31:12], 12'b0};
            immJ:
                imm = {{11{sign}}, sign, instruction[19:12], instruction[20],
                       instruction[30:21], 1'b0};
            default:
                imm = '0;                   // immNone
        endcase
    end

endmodule

// File: src/instrDecoder.sv
`timescale 1ns/10ps

module instrDecoder import rv32Pkg::*; (
    input  logic    reset,
    input  wordT    instruction,
    output logic    regWrite,
    output logic    memWrite,
    output logic    aluSrcImm,
    output aluOpE   aluOp,
    output immTypeE immType,
    output wbSelE   wbSel,
    output branchE  branchKind
);

    opcodeE     opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = opcodeE'(instruction[6:0]);
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];

    always_comb
    begin
        // Defaults describe a no-op
        regWrite   = 1'b0;
        memWrite   = 1'b0;
        aluSrcImm  = 1'b0;
        aluOp      = aluZero;
        immType    = immNone;
        wbSel      = wbAlu;
        branchKind = brNone;

        case (opcode)
            opReg:
            begin
                case ({funct7, funct3})
                    {f7Base, f3AddSub}: aluOp = aluAdd;
                    {f7Alt,  f3AddSub}: aluOp = aluSub;
                    {f7Base, f3And}:    aluOp = aluAnd;
                    {f7Base, f3Slt}:    aluOp = aluSlt;
                    {f7Base, f3Sll}:    aluOp = aluSll;
                    {f7Base, f3Shr}:    aluOp = aluSrl;
                    {f7Alt,  f3Shr}:    aluOp = aluSra;
                    default:            aluOp = aluZero;
                endcase
                regWrite = (aluOp != aluZero);      // Unknown funct fields stay a no-op
            end
            opImm:
            begin
                if (funct3 == f3AddSub)             // addi only
                begin
                    regWrite  = 1'b1;
                    aluSrcImm = 1'b1;
                    aluOp     = aluAdd;
                    immType   = immI;
                end
            end
            opLoad:
            begin
                if (funct3 == f3Word)
                begin
                    regWrite  = 1'b1;
                    aluSrcImm = 1'b1;
                    aluOp     = aluAdd;             // Base plus offset
                    immType   = immI;
                    wbSel     = wbMem;
                end
            end
            opStore:
            begin
                if (funct3 == f3Word)
                begin
                    memWrite  = 1'b1;
                    aluSrcImm = 1'b1;
                    aluOp     = aluAdd;
                    immType   = immS;
                end
            end
            opBranch:
            begin
                if (funct3 == f3Beq)
                begin
                    aluOp      = aluSub;            // Zero flag means equal
                    immType    = immB;
                    branchKind = brBeq;
                end
                else if (funct3 == f3Blt)
                begin
                    aluOp      = aluSlt;            // Signed compare
                    immType    = immB;
                    branchKind = brBlt;
                end
            end
            opLui:
            begin
                regWrite = 1'b1;
                immType  = immU;
                wbSel    = wbImm;
            end
            opAuipc:
            begin
                regWrite = 1'b1;
                immType  = immU;
                wbSel    = wbPcImm;
            end
            opJal:
            begin
                regWrite   = 1'b1;
                immType    = immJ;
                wbSel      = wbPcPlus4;             // Link value
                branchKind = brJal;
            end
            opJalr:
            begin
                if (funct3 == f3Jalr)
                begin
                    regWrite   = 1'b1;
                    aluSrcImm  = 1'b1;
                    aluOp      = aluAdd;            // rs1 plus offset as target
                    immType    = immI;
                    wbSel      = wbPcPlus4;
                    branchKind = brJalr;
                end
            end
            default:
            begin
                regWrite = 1'b0;                    // Unknown opcode
            end
        endcase

        // Keep the register file and data memory untouched during reset
        if (reset)
        begin
            regWrite = 1'b0;
            memWrite = 1'b0;
        end
    end

endmodule

// File: src/regFile.sv
`timescale 1ns/10ps

module regFile import rv32Pkg::*; (
    input  logic    clk,
    input  regAddrT rs1Addr,
    input  regAddrT rs2Addr,
    input  regAddrT rdAddr,
    input  logic    writeEnable,
    input  wordT    writeData,
    output wordT    rs1Data,
    output wordT    rs2Data
);

    wordT regs [32];

    // x0 is decoded here rather than stored
    assign rs1Data = (rs1Addr == 5'd0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == 5'd0) ? '0 : regs[rs2Addr];

    always_ff @(posedge clk)
    begin
        if (writeEnable && (rdAddr != 5'd0))
        begin
            regs[rdAddr] <= writeData;      // Visible to the next instruction
        end
    end

endmodule

// File: src/rv32Core.sv
`timescale 1ns/10ps

module rv32Core import rv32Pkg::*; #(
    parameter wordT resetVector = '0
) (
    input  logic clk,
    input  logic reset,
    output wordT pc,
    input  wordT instruction,
    output logic we,
    output wordT addressToMem,
    output wordT dataToMem,
    input  wordT dataFromMem
);

    wordT    pcPlus4;
    wordT    branchTarget;
    logic    takeBranch;

    logic    regWrite;
    logic    aluSrcImm;
    aluOpE   aluOp;
    immTypeE immType;
    wbSelE   wbSel;
    branchE  branchKind;

    wordT    imm;
    wordT    rs1Data;
    wordT    rs2Data;
    wordT    writeData;

    fetchUnit #(.resetVector(resetVector)) fetch0 (
        .clk          (clk),
        .reset        (reset),
        .takeBranch   (takeBranch),
        .branchTarget (branchTarget),
        .pc           (pc),
        .pcPlus4      (pcPlus4)
    );

    instrDecoder decode0 (
        .reset       (reset),
        .instruction (instruction),
        .regWrite    (regWrite),
        .memWrite    (we),          // Store strobe straight to the data port
        .aluSrcImm   (aluSrcImm),
        .aluOp       (aluOp),
        .immType     (immType),
        .wbSel       (wbSel),
        .branchKind  (branchKind)
    );

    immGen imm0 (
        .instruction (instruction),
        .immType     (immType),
        .imm         (imm)
    );

    regFile regs0 (
        .clk         (clk),
        .rs1Addr     (instruction[19:15]),
        .rs2Addr     (instruction[24:20]),
        .rdAddr      (instruction[11:7]),
        .writeEnable (regWrite),
        .writeData   (writeData),
        .rs1Data     (rs1Data),
        .rs2Data     (rs2Data)
    );

    executeStage exec0 (
        .pc           (pc),
        .pcPlus4      (pcPlus4),
        .rs1Data      (rs1Data),
        .rs2Data      (rs2Data),
        .imm          (imm),
        .aluSrcImm    (aluSrcImm),
        .aluOp        (aluOp),
        .wbSel        (wbSel),
        .branchKind   (branchKind),
        .dataFromMem  (dataFromMem),
        .takeBranch   (takeBranch),
        .branchTarget (branchTarget),
        .addressToMem (addressToMem),
        .dataToMem    (dataToMem),
        .writeData    (writeData)
    );

endmodule

// File: src/rv32Pkg.sv
package rv32Pkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0]  regAddrT;

    // Major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        opReg    = 7'b0110011,
        opImm    = 7'b0010011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011,
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111
    } opcodeE;

    typedef enum logic [3:0] {
        aluAdd  = 4'd1,
        aluAnd  = 4'd2,
        aluSub  = 4'd3,
        aluSlt  = 4'd4,
        aluSll  = 4'd5,
        aluSrl  = 4'd6,
        aluSra  = 4'd7,
        aluZero = 4'd15     // Result forced to 0
    } aluOpE;

    typedef enum logic [2:0] {immNone, immI, immS, immB, immU, immJ} immTypeE;

    typedef enum logic [2:0] {brNone, brBeq, brBlt, brJal, brJalr} branchE;

    // Source of the register write
    typedef enum logic [2:0] {wbAlu, wbMem, wbPcPlus4, wbImm, wbPcImm} wbSelE;

    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Shr    = 3'b101;   // srl and sra
    localparam logic [2:0] f3And    = 3'b111;
    localparam logic [2:0] f3Word   = 3'b010;   // lw and sw
    localparam logic [2:0] f3Beq    = 3'b000;
    localparam logic [2:0] f3Blt    = 3'b100;
    localparam logic [2:0] f3Jalr   = 3'b000;

    localparam logic [6:0] f7Base   = 7'b0000000;
    localparam logic [6:0] f7Alt    = 7'b0100000;   // sub and sra

endpackage
